// File: dv/fp_div_pipe_tb.sv
`timescale 1ns/1ns

module fp_div_pipe_tb;

	localparam int          clk_period   = 40;
	localparam int          reset_cycles = 8;
	localparam int          idle_cycles  = 3;
	localparam int          latency      = 5;  // pre 2 plus post 3
	localparam int          max_vecs     = 64;
	localparam int          vec_words    = 5;  // valid, a, b, z, status
	localparam int          rand_count   = 200;
	localparam logic [31:0] seed         = 32'h9d30_a0db;

	typedef struct packed {
		int          stamp; // cycle count when the pair was driven
		logic [31:0] z;
		logic [4:0]  status;
	} expect_t;

	logic                   clk;
	logic                   rst_n;
	logic [31:0]            a;
	logic [31:0]            b;
	logic                   ab_valid;
	logic [31:0]            z;
	fp_div_pkg::fp_status_t status;
	logic                   z_valid;

	logic [31:0] vec_mem [max_vecs*vec_words];
	int          num_vecs;
	int          cyc;
	logic        loaded;
	expect_t     exp_q [$];

	fp_div_pipe i_fp_div_pipe (
		.clk      (clk),
		.rst_n    (rst_n),
		.a        (a),
		.b        (b),
		.ab_valid (ab_valid),
		.z        (z),
		.status   (status),
		.z_valid  (z_valid)
	);

	always #(clk_period/2) clk = ~clk;

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1, "testbench stopped on first error");
	endtask

	// reference quotient from the format rules, truncating
	function automatic logic [36:0] model_div(input logic [31:0] x, input logic [31:0] y);
		logic            sz;
		logic            x_zero;
		logic            y_zero;
		logic            x_inf;
		logic            y_inf;
		logic            x_nan;
		logic            y_nan;
		int              ex;
		int              ey;
		int              ez;
		longint unsigned num;
		longint unsigned den;
		longint unsigned q;
		logic [31:0]     res_z;
		logic [4:0]      res_st;
		ex     = int'(x[30:23]);
		ey     = int'(y[30:23]);
		x_zero = (ex == 0); // subnormals flush
		y_zero = (ey == 0);
		x_inf  = (ex == 255) && (x[22:0] == '0);
		y_inf  = (ey == 255) && (y[22:0] == '0);
		x_nan  = (ex == 255) && (x[22:0] != '0);
		y_nan  = (ey == 255) && (y[22:0] != '0);
		sz     = x[31] ^ y[31];
		res_z  = {sz, 31'h0};
		res_st = 5'h00;
		if (x_nan || y_nan || (x_zero && y_zero) || (x_inf && y_inf)) begin
			res_z  = 32'h7fc0_0000;
			res_st = 5'h10;
		end else if (x_inf) begin
			res_z = {sz, 8'hff, 23'h0};
		end else if (y_inf) begin
			res_st = 5'h01;
		end else if (y_zero) begin
			res_z  = {sz, 8'hff, 23'h0};
			res_st = 5'h08;
		end else if (x_zero) begin
			res_st = 5'h01;
		end else begin
			num = 64'({1'b1, x[22:0]}) << 25;
			den = 64'({1'b1, y[22:0]});
			q   = num / den;
			ez  = ex - ey + 127;
			if (!q[25]) begin
				q  = q << 1; // ratio below one
				ez = ez - 1;
			end
			if (ez >= 255) begin
				res_z  = {sz, 8'hff, 23'h0};
				res_st = 5'h04;
			end else if (ez <= 0) begin
				res_st = 5'h03;
			end else begin
				res_z = {sz, 8'(ez), q[24:2]};
			end
		end
		return {res_z, res_st};
	endfunction

	// mostly moderate exponents, now and then any bit pattern
	function automatic logic [31:0] random_operand();
		logic [31:0] r;
		logic [7:0]  e;
		r = $urandom();
		if ($urandom_range(7, 0) == 0) begin
			return r;
		end
		e = 8'($urandom_range(191, 64));
		return {r[31], e, r[22:0]};
	endfunction

	task automatic drive_pair(input logic valid, input logic [31:0] op_a,
			input logic [31:0] op_b, input logic [31:0] exp_z, input logic [4:0] exp_status);
		expect_t e;
		a        = op_a;
		b        = op_b;
		ab_valid = valid;
		if (valid) begin
			e.stamp  = cyc;
			e.z      = exp_z;
			e.status = exp_status;
			exp_q.push_back(e);
		end
	endtask

	// results must leave in order, each after the fixed latency
	always @(posedge clk) begin
		expect_t e;
		cyc <= cyc + 1;
		if (z_valid) begin
			assert (exp_q.size() != 0)
			else abort_run("z_valid pulse arrived with no result pending");
			e = exp_q.pop_front();
			assert (cyc - e.stamp == latency)
			else abort_run($sformatf("result came %0d cycles after its strobe, not %0d",
				cyc - e.stamp, latency));
			assert (z === e.z)
			else abort_run($sformatf("FAIL z expected %h got %h", e.z, z));
			assert (status === e.status)
			else abort_run($sformatf("FAIL status expected %h got %h", e.status, status));
		end
	end

	initial begin
		int limit;
		wait (loaded);
		limit = num_vecs + rand_count + reset_cycles + idle_cycles + 20;
		#(limit * clk_period);
		abort_run($sformatf("timeout, the run did not finish within %0d cycles", limit));
	end

	initial begin
		logic [36:0] ref_res;
		logic [31:0] ra;
		logic [31:0] rb;
		int          base;
		clk      = 1'b0;
		rst_n    = 1'b0;
		a        = '0;
		b        = '0;
		ab_valid = 1'b0;
		cyc      = 0;
		loaded   = 1'b0;
		num_vecs = 0;
		void'($urandom(seed));

		$readmemh("dv/fp_div_testdata.hex", vec_mem);
		while (num_vecs < max_vecs && vec_mem[num_vecs*vec_words] != 32'd2) begin
			num_vecs++; // valid column 2 ends the list
		end
		assert (num_vecs > 0)
		else abort_run("no vectors found in dv/fp_div_testdata.hex");
		loaded = 1'b1;

		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		// stage registers are cleared while reset is held
		assert (z_valid === 1'b0)
		else abort_run($sformatf("FAIL z_valid expected 0 got %h", z_valid));
		assert (z === '0)
		else abort_run($sformatf("FAIL z expected %h got %h", 32'h0, z));
		assert (status === '0)
		else abort_run($sformatf("FAIL status expected %h got %h", 5'h0, status));
		rst_n = 1'b1;

		// stages keep loading, but no strobe means no valid tag
		repeat (idle_cycles) begin
			@(negedge clk);
			assert (z_valid === 1'b0)
			else abort_run($sformatf("FAIL z_valid expected 0 got %h", z_valid));
		end

		for (int i = 0; i < num_vecs; i++) begin
			base = i * vec_words;
			@(negedge clk);
			drive_pair(vec_mem[base][0], vec_mem[base+1], vec_mem[base+2],
				vec_mem[base+3], vec_mem[base+4][4:0]);
		end

		// back-to-back random pairs
		for (int i = 0; i < rand_count; i++) begin
			ra      = random_operand();
			rb      = random_operand();
			ref_res = model_div(ra, rb);
			@(negedge clk);
			drive_pair(1'b1, ra, rb, ref_res[36:5], ref_res[4:0]);
		end
		@(negedge clk);
		drive_pair(1'b0, '0, '0, '0, '0);

		repeat (latency + 2) @(negedge clk); // last result plus room for stray pulses

		if (exp_q.size() == 0) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			abort_run($sformatf("%0d results never arrived", exp_q.size()));
		end
	end

endmodule

// File: dv/fp_div_testdata.hex
// columns: valid a b expected_z expected_status, valid 0 is a gap, valid 2 ends the list
// status bits from msb: invalid div_by_zero overflow underflow zero
1 3f800000 3f800000 3f800000 00
1 3f800000 40000000 3f000000 00
1 40c00000 40000000 40400000 00
1 40000000 40c00000 3eaaaaaa 00
0 12345678 9abcdef0 00000000 00
1 bf800000 40400000 beaaaaaa 00
1 3f800000 c0400000 beaaaaaa 00
1 c0c00000 c0000000 40400000 00
1 41200000 40800000 40200000 00
0 00000000 00000000 00000000 00
0 7fc00000 00000000 00000000 00
1 3f800000 41200000 3dcccccc 00
1 40e00000 40400000 40155555 00
1 3fc00000 3fa00000 3f999999 00
1 3f800000 3fffffff 3f000000 00
1 3f7fffff 3f800000 3f7fffff 00
1 7f7fffff 3f800000 7f7fffff 00
1 7f000000 3f800000 7f000000 00
1 7f000000 3f000000 7f800000 04
1 ff000000 3e800000 ff800000 04
1 7f000000 3f7fffff 7f000000 00
0 deadbeef 00000000 00000000 00
1 00800000 40000000 00000000 03
1 80800000 3f800000 80800000 00
1 00800000 3fc00000 00000000 03
1 00800000 bfc00000 80000000 03
1 00400000 3f800000 00000000 01
1 3f800000 00000001 7f800000 08
1 bf800000 80400000 7f800000 08
1 00000001 80000001 7fc00000 10
0 3f800000 3f800000 00000000 00
1 7fc00000 3f800000 7fc00000 10
1 3f800000 ffc00001 7fc00000 10
1 7f800001 00000000 7fc00000 10
1 00000000 80000000 7fc00000 10
1 7f800000 ff800000 7fc00000 10
1 7f800000 c0000000 ff800000 00
1 ff800000 00000000 ff800000 00
1 40400000 ff800000 80000000 01
1 80000000 7f800000 80000000 01
1 40a00000 80000000 ff800000 08
1 80000000 40400000 80000000 01
1 00000000 c0400000 80000000 01
0 00000000 00000000 00000000 00
0 00000000 00000000 00000000 00
1 3f800000 3f800000 3f800000 00
2 00000000 00000000 00000000 00

// File: fp_div_pipe.f
logic/fp_format_pkg.sv
logic/fp_div_pkg.sv
logic/fp_div_unpack.sv
logic/fp_mant_divider.sv
logic/fp_div_pack.sv
logic/fp_retime_pipe.sv
logic/fp_div_pipe.sv
dv/fp_div_pipe_tb.sv

// File: logic/fp_div_pack.sv
`timescale 1ns/1ns

module fp_div_pack (
	input  fp_div_pkg::fp_quot_t   quot,
	output fp_div_pkg::fp_result_t result
);

	localparam logic [31:0] qnan_word = 32'h7fc0_0000;

	logic              a_nan;
	logic              b_nan;
	logic              a_inf;
	logic              b_inf;
	logic              a_zero;
	logic              b_zero;
	logic signed [9:0] raw_exp;
	logic [31:0]       inf_word;
	logic [31:0]       zero_word;

	assign a_nan  = (quot.cls_a == fp_format_pkg::fp_nan);
	assign b_nan  = (quot.cls_b == fp_format_pkg::fp_nan);
	assign a_inf  = (quot.cls_a == fp_format_pkg::fp_inf);
	assign b_inf  = (quot.cls_b == fp_format_pkg::fp_inf);
	assign a_zero = (quot.cls_a == fp_format_pkg::fp_zero);
	assign b_zero = (quot.cls_b == fp_format_pkg::fp_zero);

	assign raw_exp = quot.exp;

	// signed specials
	assign inf_word  = {quot.sign, 8'hff, 23'b0};
	assign zero_word = {quot.sign, 31'b0};

	always_comb begin
		result.z      = zero_word;
		result.status = '0;

		// precedence: invalid, inf/x, x/inf, x/0, 0/x, then range
		if (a_nan || b_nan || (a_zero && b_zero) || (a_inf && b_inf)) begin
			result.z              = qnan_word;
			result.status.invalid = 1'b1;
		end else if (a_inf) begin
			result.z = inf_word; // exact, no flag
		end else if (b_inf) begin
			result.z           = zero_word;
			result.status.zero = 1'b1;
		end else if (b_zero) begin
			result.z                  = inf_word;
			result.status.div_by_zero = 1'b1;
		end else if (a_zero) begin
			result.z           = zero_word;
			result.status.zero = 1'b1;
		end else if (raw_exp >= fp_format_pkg::exp_max) begin
			result.z               = inf_word;
			result.status.overflow = 1'b1;
		end else if (raw_exp <= 0) begin
			// flushed, no subnormal results
			result.z                = zero_word;
			result.status.underflow = 1'b1;
			result.status.zero      = 1'b1;
		end else begin
			result.z = {quot.sign, raw_exp[7:0], quot.frac};
		end
	end

endmodule

// File: logic/fp_div_pipe.sv
`timescale 1ns/1ns

module fp_div_pipe #(
	parameter int pre_stages  = 2,
	parameter int post_stages = 3
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [31:0]           a,
	input  logic [31:0]           b,
	input  logic                  ab_valid,
	output logic [31:0]           z,
	output fp_div_pkg::fp_status_t status,
	output logic                  z_valid
);

	fp_format_pkg::fp_unpacked_t unp_a;
	fp_format_pkg::fp_unpacked_t unp_b;
	fp_div_pkg::fp_quot_t        quot_comb;
	fp_div_pkg::fp_quot_t        quot_q;
	logic                        quot_valid;
	fp_div_pkg::fp_result_t      res_comb;
	fp_div_pkg::fp_result_t      res_q;

	fp_div_unpack i_unpack_a (
		.operand  (a),
		.unpacked (unp_a)
	);

	fp_div_unpack i_unpack_b (
		.operand  (b),
		.unpacked (unp_b)
	);

	fp_mant_divider i_mant_divider (
		.op_a (unp_a),
		.op_b (unp_b),
		.quot (quot_comb)
	);

	// retiming ahead of the exception logic
	fp_retime_pipe #(
		.stages    (pre_stages),
		.payload_t (fp_div_pkg::fp_quot_t)
	) i_pre_pipe (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_data   (quot_comb),
		.in_valid  (ab_valid),
		.out_data  (quot_q),
		.out_valid (quot_valid)
	);

	fp_div_pack i_pack (
		.quot   (quot_q),
		.result (res_comb)
	);

	fp_retime_pipe #(
		.stages    (post_stages),
		.payload_t (fp_div_pkg::fp_result_t)
	) i_post_pipe (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_data   (res_comb),
		.in_valid  (quot_valid),
		.out_data  (res_q),
		.out_valid (z_valid)
	);

	assign z      = res_q.z;
	assign status = res_q.status;

endmodule

// File: logic/fp_div_pkg.sv
package fp_div_pkg;

	// status flags, invalid is the msb
	typedef struct packed {
		logic invalid;
		logic div_by_zero;
		logic overflow;
		logic underflow;
		logic zero;
	} fp_status_t;

	// quotient stage, before exceptions are resolved
	typedef struct packed {
		logic                                 sign;
		logic signed [9:0]                    exp;   // biased, may leave 1..254
		logic [fp_format_pkg::sig_width-1:0] frac;  // truncated
		fp_format_pkg::fp_class_t             cls_a;
		fp_format_pkg::fp_class_t             cls_b;
	} fp_quot_t;

	// final word plus flags
	typedef struct packed {
		logic [31:0] z;
		fp_status_t  status;
	} fp_result_t;

endpackage

// File: logic/fp_div_unpack.sv
`timescale 1ns/1ns

module fp_div_unpack (
	input  logic [31:0]                 operand,
	output fp_format_pkg::fp_unpacked_t unpacked
);

	logic [fp_format_pkg::exp_width-1:0] exp_field;
	logic [fp_format_pkg::sig_width-1:0] frac_field;
	logic                                exp_zero;
	logic                                exp_ones;

	assign exp_field  = operand[fp_format_pkg::sig_width +: fp_format_pkg::exp_width];
	assign frac_field = operand[fp_format_pkg::sig_width-1:0];

	assign exp_zero = (exp_field == '0);
	assign exp_ones = (exp_field == fp_format_pkg::exp_width'(fp_format_pkg::exp_max));

	always_comb begin
		unpacked.sign = operand[31];
		unpacked.exp  = exp_field;
		unpacked.sig  = {~exp_zero, frac_field}; // hidden bit

		// subnormals land in fp_zero here
		if (exp_zero) begin
			unpacked.cls = fp_format_pkg::fp_zero;
		end else if (exp_ones) begin
			if (frac_field == '0) begin
				unpacked.cls = fp_format_pkg::fp_inf;
			end else begin
				unpacked.cls = fp_format_pkg::fp_nan;
			end
		end else begin
			unpacked.cls = fp_format_pkg::fp_normal;
		end
	end

endmodule

// File: logic/fp_format_pkg.sv
package fp_format_pkg;

	// binary32 field layout
	localparam int exp_width = 8;
	localparam int sig_width = 23;

	localparam int exp_bias = 127;
	localparam int exp_max  = 255; // all-ones exponent, inf or nan

	// operand classes after unpacking
	// subnormals are flushed and count as fp_zero
	typedef enum logic [1:0] {
		fp_zero   = 2'd0,
		fp_normal = 2'd1,
		fp_inf    = 2'd2,
		fp_nan    = 2'd3
	} fp_class_t;

	// one operand split into fields
	// the significand carries the hidden bit at the top
	typedef struct packed {
		logic                 sign;
		logic [exp_width-1:0] exp;
		logic [sig_width:0]   sig;
		fp_class_t            cls;
	} fp_unpacked_t;

endpackage

// File: logic/fp_mant_divider.sv
`timescale 1ns/1ns

module fp_mant_divider (
	input  fp_format_pkg::fp_unpacked_t op_a,
	input  fp_format_pkg::fp_unpacked_t op_b,
	output fp_div_pkg::fp_quot_t        quot
);

	localparam int sig_bits = fp_format_pkg::sig_width + 1; // with hidden bit
	localparam int div_bits = sig_bits + 25;

	logic signed [9:0]           exp_raw;
	logic [div_bits-1:0]         dividend;
	logic [div_bits-1:0]         divisor;
	logic [25:0]                 q_raw;
	logic [25:0]                 q_norm;
	logic signed [9:0]           exp_norm;

	// biased exponent, exponent fields are zero extended first
	assign exp_raw = $signed({2'b00, op_a.exp}) - $signed({2'b00, op_b.exp})
		+ 10'(fp_format_pkg::exp_bias);

	assign dividend = {op_a.sig, 25'b0};
	assign divisor  = div_bits'(op_b.sig);

	// for normal operands the ratio is in (0.5, 2), so 26 bits hold it
	always_comb begin
		if (op_b.sig == '0) begin
			q_raw = '0; // zero divisor, pack picks the result
		end else begin
			q_raw = 26'(dividend / divisor);
		end
	end

	// one bit normalize
	always_comb begin
		if (q_raw[25]) begin
			q_norm   = q_raw;
			exp_norm = exp_raw;
		end else begin
			q_norm   = {q_raw[24:0], 1'b0};
			exp_norm = exp_raw - 10'sd1;
		end
	end

	always_comb begin
		quot.sign  = op_a.sign ^ op_b.sign;
		quot.exp   = exp_norm;
		quot.frac  = q_norm[24:2]; // truncate, low bits dropped
		quot.cls_a = op_a.cls;     // classes only ride along
		quot.cls_b = op_b.cls;
	end

endmodule

// File: logic/fp_retime_pipe.sv
`timescale 1ns/1ns

module fp_retime_pipe #(
	parameter int  stages    = 1,
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst_n,
	input  payload_t in_data,
	input  logic     in_valid,
	output payload_t out_data,
	output logic     out_valid
);

	// one stage register, data with its valid tag
	typedef struct packed {
		logic     valid;
		payload_t data;
	} stage_t;

	stage_t stage_q [stages];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < stages; i++) begin
				stage_q[i] <= stage_t'(0);
			end
		end else begin
			// loads every cycle, the tag marks real pairs
			stage_q[0].valid <= in_valid;
			stage_q[0].data  <= in_data;
			for (int i = 1; i < stages; i++) begin
				stage_q[i] <= stage_q[i-1];
			end
		end
	end

	assign out_data  = stage_q[stages-1].data;
	assign out_valid = stage_q[stages-1].valid;

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the divider testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f fp_div_pipe.f \
	--top-module fp_div_pipe_tb \
	--Mdir obj_dir \
	-o fp_div_pipe_tb
build_status=$?
if [ "$build_status" -ne 0 ]; then
	echo "verilator build failed with status $build_status"
	exit "$build_status"
fi

./obj_dir/fp_div_pipe_tb
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
	echo "simulation ended with status $sim_status"
	exit "$sim_status"
fi

exit 0
